/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f build.f --top-module tb_rv_core -o tb_sim
	./obj_dir/tb_sim | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

/* build.f */
+incdir+.
rv_pkg.sv
rv_regfile.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_core.sv
tb_clkgen.sv
tb_rv_core.sv

/* rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_core
    import rv_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst,

    input  logic i_enable,

    input  logic [`RV_XLEN-1:0] i_mem_data,

    output logic [`RV_MEM_AW-1:0] o_mem_addr,
    output logic                  o_is_halted,
    output retire_t               o_retire
);

logic                w_capture;
logic                w_exec;
logic [`RV_XLEN-1:0] w_pc;
logic [`RV_XLEN-1:0] w_next_pc;
logic [`RV_XLEN-1:0] w_inst;
decoded_inst_t       w_dec;

rv_fetch u_fetch
(
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_enable     (i_enable),
    .i_inst_valid (w_dec.valid),
    .i_next_pc    (w_next_pc),
    .o_mem_addr   (o_mem_addr),
    .o_capture    (w_capture),
    .o_exec       (w_exec),
    .o_pc         (w_pc),
    .o_is_halted  (o_is_halted)
);

rv_decode u_decode
(
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_enable   (i_enable),
    .i_capture  (w_capture),
    .i_mem_data (i_mem_data),
    .o_inst     (w_inst),
    .o_dec      (w_dec)
);

rv_execute u_execute
(
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_enable  (i_enable),
    .i_exec    (w_exec),
    .i_pc      (w_pc),
    .i_inst    (w_inst),
    .i_dec     (w_dec),
    .o_next_pc (w_next_pc),
    .o_retire  (o_retire)
);

endmodule

`default_nettype wire

/* rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_decode
    import rv_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst,

    input  logic i_enable,

    input  logic                i_capture,
    input  logic [`RV_XLEN-1:0] i_mem_data,

    output logic [`RV_XLEN-1:0] o_inst,
    output decoded_inst_t       o_dec
);

logic [`RV_XLEN-1:0] r_inst;

logic [6:0] w_opc;
logic [2:0] w_f3;
logic [6:0] w_f7;

logic [`RV_XLEN-1:0] w_imm_i;
logic [`RV_XLEN-1:0] w_imm_u;
logic [`RV_XLEN-1:0] w_imm_b;
logic [`RV_XLEN-1:0] w_imm_j;

logic          w_writes;
decoded_inst_t w_dec;

// an all-zero word decodes invalid
always_ff @(posedge i_clk)
begin
    if (i_rst)
        r_inst <= '0;
    else if (i_enable && i_capture)
        r_inst <= i_mem_data;
end

assign w_opc = r_inst[6:0];
assign w_f3  = r_inst[14:12];
assign w_f7  = r_inst[31:25];

assign w_imm_i = {{20{r_inst[31]}}, r_inst[31:20]};
assign w_imm_u = {r_inst[31:12], 12'b0};
assign w_imm_b = {{19{r_inst[31]}}, r_inst[31], r_inst[7], r_inst[30:25], r_inst[11:8], 1'b0};
assign w_imm_j = {{11{r_inst[31]}}, r_inst[31], r_inst[19:12], r_inst[20], r_inst[30:21], 1'b0};

always_comb
begin
    w_dec        = '0;
    w_dec.opcode = opcode_e'(w_opc);
    w_dec.alu_op = alu_add;
    w_dec.rd     = r_inst[11:7];
    w_dec.rs1    = r_inst[19:15];
    w_dec.rs2    = r_inst[24:20];
    w_writes     = 1'b0;

    case (w_opc)
        opc_lui:
        begin
            w_dec.valid   = 1'b1;
            w_dec.alu_op  = alu_pass_b;
            w_dec.use_imm = 1'b1;
            w_dec.imm     = w_imm_u;
            w_writes      = 1'b1;
        end
        opc_auipc:
        begin
            w_dec.valid = 1'b1;
            w_dec.imm   = w_imm_u;
            w_writes    = 1'b1;
        end
        opc_jal:
        begin
            w_dec.valid = 1'b1;
            w_dec.imm   = w_imm_j;
            w_writes    = 1'b1;
        end
        opc_jalr:
        begin
            w_dec.valid   = (w_f3 == 3'b000);
            w_dec.use_imm = 1'b1;
            w_dec.imm     = w_imm_i;
            w_writes      = 1'b1;
        end
        opc_branch:
        begin
            w_dec.valid = 1'b1;
            w_dec.imm   = w_imm_b;
            case (w_f3)
                3'b000:  w_dec.alu_op = alu_eq;
                3'b001:  w_dec.alu_op = alu_ne;
                3'b100:  w_dec.alu_op = alu_lt;
                3'b101:  w_dec.alu_op = alu_ge;
                3'b110:  w_dec.alu_op = alu_ltu;
                3'b111:  w_dec.alu_op = alu_geu;
                default: w_dec.valid  = 1'b0;
            endcase
        end
        opc_op_imm:
        begin
            w_dec.valid   = 1'b1;
            w_dec.use_imm = 1'b1;
            w_dec.imm     = w_imm_i;
            w_writes      = 1'b1;
            case (w_f3)
                3'b000: w_dec.alu_op = alu_add;
                3'b010: w_dec.alu_op = alu_slt;
                3'b011: w_dec.alu_op = alu_sltu;
                3'b100: w_dec.alu_op = alu_xor;
                3'b110: w_dec.alu_op = alu_or;
                3'b111: w_dec.alu_op = alu_and;
                3'b001:
                begin
                    w_dec.alu_op = alu_sll;
                    w_dec.valid  = (w_f7 == 7'b0000000);
                end
                3'b101:
                begin
                    if (w_f7 == 7'b0000000)
                        w_dec.alu_op = alu_srl;
                    else if (w_f7 == 7'b0100000)
                        w_dec.alu_op = alu_sra;
                    else
                        w_dec.valid = 1'b0;
                end
            endcase
        end
        opc_op:
        begin
            w_dec.valid = 1'b1;
            w_writes    = 1'b1;
            case ({w_f7, w_f3})
                {7'b0000000, 3'b000}: w_dec.alu_op = alu_add;
                {7'b0100000, 3'b000}: w_dec.alu_op = alu_sub;
                {7'b0000000, 3'b001}: w_dec.alu_op = alu_sll;
                {7'b0000000, 3'b010}: w_dec.alu_op = alu_slt;
                {7'b0000000, 3'b011}: w_dec.alu_op = alu_sltu;
                {7'b0000000, 3'b100}: w_dec.alu_op = alu_xor;
                {7'b0000000, 3'b101}: w_dec.alu_op = alu_srl;
                {7'b0100000, 3'b101}: w_dec.alu_op = alu_sra;
                {7'b0000000, 3'b110}: w_dec.alu_op = alu_or;
                {7'b0000000, 3'b111}: w_dec.alu_op = alu_and;
                default:              w_dec.valid  = 1'b0;
            endcase
        end
        default:
        begin
            // loads, stores, fence and system all land here
            w_dec.valid = 1'b0;
        end
    endcase

    w_dec.rd_we = w_dec.valid && w_writes && (w_dec.rd != 5'd0);
end

assign o_inst = r_inst;
assign o_dec  = w_dec;

endmodule

`default_nettype wire

/* rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// data path and register width
`define RV_XLEN 32

// word address into the program memory, taken from the low bits of the pc
`define RV_MEM_AW 14

// architectural registers, x0 included
`define RV_NREGS 32

// pc advance for a sequential instruction
`define RV_PC_STEP 4

`endif

/* rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_execute
    import rv_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst,

    input  logic i_enable,

    input  logic                i_exec,
    input  logic [`RV_XLEN-1:0] i_pc,
    input  logic [`RV_XLEN-1:0] i_inst,
    input  decoded_inst_t       i_dec,

    output logic [`RV_XLEN-1:0] o_next_pc,
    output retire_t             o_retire
);

logic [`RV_XLEN-1:0] w_rs1_data;
logic [`RV_XLEN-1:0] w_rs2_data;
logic [`RV_XLEN-1:0] w_op_b;
logic [4:0]          w_shamt;
logic [`RV_XLEN-1:0] w_alu;
logic                w_cond;
logic [`RV_XLEN-1:0] w_pc_seq;
logic [`RV_XLEN-1:0] w_pc_imm;
logic [`RV_XLEN-1:0] w_result;
logic [`RV_XLEN-1:0] w_next_pc;
logic                w_we;
retire_t             r_retire;

rv_regfile u_regfile
(
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_we       (w_we),
    .i_rd       (i_dec.rd),
    .i_rs1      (i_dec.rs1),
    .i_rs2      (i_dec.rs2),
    .i_wdata    (w_result),
    .o_rs1_data (w_rs1_data),
    .o_rs2_data (w_rs2_data)
);

assign w_op_b   = i_dec.use_imm ? i_dec.imm : w_rs2_data;
assign w_shamt  = w_op_b[4:0];
assign w_pc_seq = i_pc + `RV_PC_STEP;
assign w_pc_imm = i_pc + i_dec.imm;

// compares leave their outcome in w_cond, which also feeds slt/sltu
always_comb
begin
    w_cond = 1'b0;
    w_alu  = '0;
    case (i_dec.alu_op)
        alu_add:    w_alu = w_rs1_data + w_op_b;
        alu_sub:    w_alu = w_rs1_data - w_op_b;
        alu_sll:    w_alu = w_rs1_data << w_shamt;
        alu_xor:    w_alu = w_rs1_data ^ w_op_b;
        alu_srl:    w_alu = w_rs1_data >> w_shamt;
        alu_sra:    w_alu = $signed(w_rs1_data) >>> w_shamt;
        alu_or:     w_alu = w_rs1_data | w_op_b;
        alu_and:    w_alu = w_rs1_data & w_op_b;
        alu_pass_b: w_alu = w_op_b;
        alu_eq:     w_cond = (w_rs1_data == w_op_b);
        alu_ne:     w_cond = (w_rs1_data != w_op_b);
        alu_slt,
        alu_lt:     w_cond = ($signed(w_rs1_data) < $signed(w_op_b));
        alu_ge:     w_cond = ($signed(w_rs1_data) >= $signed(w_op_b));
        alu_sltu,
        alu_ltu:    w_cond = (w_rs1_data < w_op_b);
        alu_geu:    w_cond = (w_rs1_data >= w_op_b);
        default:    w_alu = '0;
    endcase

    if ((i_dec.alu_op == alu_slt) || (i_dec.alu_op == alu_sltu))
        w_alu = {{(`RV_XLEN-1){1'b0}}, w_cond};
end

always_comb
begin
    w_result  = w_alu;
    w_next_pc = w_pc_seq;
    case (i_dec.opcode)
        opc_auipc:
        begin
            w_result = w_pc_imm;
        end
        opc_jal:
        begin
            w_result  = w_pc_seq;
            w_next_pc = w_pc_imm;
        end
        opc_jalr:
        begin
            w_result  = w_pc_seq;
            w_next_pc = {w_alu[`RV_XLEN-1:1], 1'b0};
        end
        opc_branch:
        begin
            if (w_cond)
                w_next_pc = w_pc_imm;
        end
        default:
        begin
            w_result = w_alu;
        end
    endcase
end

assign w_we = i_exec && i_dec.rd_we;

// valid pulses only for the cycle after an exec, payload holds otherwise
always_ff @(posedge i_clk)
begin
    if (i_rst)
    begin
        r_retire <= '0;
    end
    else
    begin
        if (i_enable && i_exec)
        begin
            r_retire.pc      <= i_pc;
            r_retire.rd_we   <= i_dec.rd_we;
            r_retire.rd      <= i_dec.rd;
            r_retire.rd_data <= w_result;
            r_retire.next_pc <= w_next_pc;
            r_retire.inst    <= i_inst;
        end
        r_retire.valid <= i_enable && i_exec;
    end
end

assign o_next_pc = w_next_pc;
assign o_retire  = r_retire;

endmodule

`default_nettype wire

/* rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_fetch
    import rv_pkg::*;
(
    input  logic i_clk,
    input  logic i_rst,

    input  logic i_enable,

    input  logic                i_inst_valid,
    input  logic [`RV_XLEN-1:0] i_next_pc,

    output logic [`RV_MEM_AW-1:0] o_mem_addr,
    output logic                  o_capture,
    output logic                  o_exec,
    output logic [`RV_XLEN-1:0]   o_pc,
    output logic                  o_is_halted
);

cpu_state_e r_state;

logic [`RV_XLEN-1:0]   r_pc;
logic [`RV_MEM_AW-1:0] r_mem_addr;

always_ff @(posedge i_clk)
begin
    if (i_rst)
    begin
        r_state    <= cpu_state_init;
        r_pc       <= '0;
        r_mem_addr <= '0;
    end
    else if (i_enable)
    begin
        case (r_state)
            cpu_state_init:
            begin
                r_state <= cpu_state_fetch;
            end
            cpu_state_fetch:
            begin
                // memory answers during capture
                r_mem_addr <= r_pc[`RV_MEM_AW-1:0];
                r_state    <= cpu_state_fetch_wait;
            end
            cpu_state_fetch_wait:
            begin
                r_state <= cpu_state_capture;
            end
            cpu_state_capture:
            begin
                r_state <= cpu_state_execute;
            end
            cpu_state_execute:
            begin
                if (i_inst_valid)
                begin
                    r_pc    <= i_next_pc;
                    r_state <= cpu_state_fetch;
                end
                else
                begin
                    r_state <= cpu_state_halt;
                end
            end
            default:
            begin
                // halt is left only through reset
                r_state <= cpu_state_halt;
            end
        endcase
    end
end

assign o_capture   = i_enable && (r_state == cpu_state_capture);
assign o_exec      = i_enable && (r_state == cpu_state_execute) && i_inst_valid;
assign o_mem_addr  = r_mem_addr;
assign o_pc        = r_pc;
assign o_is_halted = (r_state == cpu_state_halt);

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

    typedef enum logic [2:0]
    {
        cpu_state_init,
        cpu_state_fetch,
        cpu_state_fetch_wait,
        cpu_state_capture,
        cpu_state_execute,
        cpu_state_halt
    } cpu_state_e;

    // major opcodes still supported
    typedef enum logic [6:0]
    {
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011
    } opcode_e;

    // 17 operations, so five bits
    typedef enum logic [4:0]
    {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_eq,
        alu_ne,
        alu_lt,
        alu_ge,
        alu_ltu,
        alu_geu,
        alu_pass_b
    } alu_op_e;

    typedef struct packed
    {
        logic                valid;
        opcode_e             opcode;
        alu_op_e             alu_op;
        logic [4:0]          rd;
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic                use_imm;
        logic [`RV_XLEN-1:0] imm;
        logic                rd_we;
    } decoded_inst_t;

    // commit record, one per executed instruction
    typedef struct packed
    {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic                rd_we;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] rd_data;
        logic [`RV_XLEN-1:0] next_pc;
        logic [`RV_XLEN-1:0] inst;
    } retire_t;

endpackage

`default_nettype wire

/* rv_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module rv_regfile
(
    input  logic i_clk,
    input  logic i_rst,

    input  logic                i_we,
    input  logic [4:0]          i_rd,
    input  logic [4:0]          i_rs1,
    input  logic [4:0]          i_rs2,
    input  logic [`RV_XLEN-1:0] i_wdata,

    output logic [`RV_XLEN-1:0] o_rs1_data,
    output logic [`RV_XLEN-1:0] o_rs2_data
);

// x0 has no storage
logic [`RV_XLEN-1:0] r_regs [`RV_NREGS-1:1];

always_ff @(posedge i_clk)
begin
    if (i_rst)
    begin
        for (int i = 1; i < `RV_NREGS; i++)
            r_regs[i] <= '0;
    end
    else if (i_we && (i_rd != 5'd0))
    begin
        r_regs[i_rd] <= i_wdata;
    end
end

assign o_rs1_data = (i_rs1 == 5'd0) ? '0 : r_regs[i_rs1];
assign o_rs2_data = (i_rs2 == 5'd0) ? '0 : r_regs[i_rs2];

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen
(
    output logic o_clk,
    output logic o_rst
);

// 10 ns period
initial
begin
    o_clk = 1'b0;
    forever #5 o_clk = ~o_clk;
end

initial
begin
    o_rst = 1'b1;
    repeat (10) @(posedge o_clk);
    o_rst <= 1'b0;
end

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module tb_rv_core
    import rv_pkg::*;
();

localparam int PROG_LEN     = 200;
localparam int LIMIT_CYCLES = 2 * (PROG_LEN * 8 + 100 + 80);

// slot kinds of the generated program
localparam int K_LUI   = 0;
localparam int K_AUIPC = 1;
localparam int K_OPIMM = 2;
localparam int K_OP    = 3;
localparam int K_BR    = 4;
localparam int K_JAL   = 5;
localparam int K_BASE  = 6;
localparam int K_JALR  = 7;

logic                  clk;
logic                  gen_rst;
logic                  rerun_rst;
logic                  dut_rst;
logic                  enable;
logic [`RV_XLEN-1:0]   mem_data;
logic [`RV_MEM_AW-1:0] mem_addr;
logic                  halted;
retire_t               retire;

logic [31:0] mem [4096];
logic [15:0] lfsr_state;
int          kind [PROG_LEN];

logic [31:0] m_regs [32];
logic [31:0] m_pc;

assign dut_rst = gen_rst | rerun_rst;

tb_clkgen u_clkgen
(
    .o_clk (clk),
    .o_rst (gen_rst)
);

rv_core uut
(
    .i_clk       (clk),
    .i_rst       (dut_rst),
    .i_enable    (enable),
    .i_mem_data  (mem_data),
    .o_mem_addr  (mem_addr),
    .o_is_halted (halted),
    .o_retire    (retire)
);

// one-cycle registered read, word addressed
always @(posedge clk)
    mem_data <= mem[mem_addr[13:2]];

// galois lfsr, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++)
    begin
        if (lfsr_state[0])
            lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
        else
            lfsr_state = lfsr_state >> 1;
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// roughly one cycle in four is stalled
always @(posedge clk)
    enable <= (rand_bits(2) != 32'd0);

function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [31:0] rs1,
                                      input logic [31:0] f3, input logic [31:0] rd,
                                      input logic [31:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic logic [31:0] enc_r(input logic [31:0] f7, input logic [31:0] rs2,
                                      input logic [31:0] rs1, input logic [31:0] f3,
                                      input logic [31:0] rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
endfunction

function automatic logic [31:0] enc_b(input logic [31:0] off, input logic [31:0] rs2,
                                      input logic [31:0] rs1, input logic [31:0] f3);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [31:0] off, input logic [31:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
endfunction

// forward target that never lands on a jalr without its base load
function automatic int pick_target(input int i);
    int t;
    t = i + 1 + int'(rand_bits(3));
    if (t > PROG_LEN - 1)
        t = PROG_LEN - 1;
    if (kind[t] == K_JALR)
        t = t + 1;
    return t;
endfunction

task automatic build_program();
    int          i;
    int          r;
    int          t;
    logic [31:0] f3;
    logic [31:0] f7;
    for (int a = 0; a < 4096; a++)
        mem[a] = '0;
    i = 0;
    while (i < PROG_LEN - 1)
    begin
        r = int'(rand_bits(4));
        kind[i] = (r < 1) ? K_LUI : (r < 2) ? K_AUIPC : (r < 10) ? ((r < 6) ? K_OPIMM : K_OP) :
                  (r < 12) ? K_BR : (r < 13) ? K_JAL : K_OPIMM;
        if (r == 13 && i <= PROG_LEN - 3)
        begin
            kind[i]     = K_BASE;
            kind[i + 1] = K_JALR;
            i = i + 1;
        end
        i = i + 1;
    end
    kind[PROG_LEN - 1] = K_LUI;
    for (int k = 0; k < PROG_LEN - 1; k++)
    begin
        case (kind[k])
            K_LUI:   mem[k[11:0]] = {20'(rand_bits(20)), 5'(rand_bits(5)), 7'b0110111};
            K_AUIPC: mem[k[11:0]] = {20'(rand_bits(20)), 5'(rand_bits(5)), 7'b0010111};
            K_OPIMM:
            begin
                f3 = rand_bits(3);
                if (f3 == 32'd1 || f3 == 32'd5)
                begin
                    f7 = (f3 == 32'd5 && rand_bits(1) == 32'd1) ? 32'h20 : 32'h0;
                    mem[k[11:0]] = enc_i(32'({f7[6:0], 5'(rand_bits(5))}), rand_bits(5), f3,
                                         rand_bits(5), 32'h13);
                end
                else
                    mem[k[11:0]] = enc_i(rand_bits(12), rand_bits(5), f3, rand_bits(5), 32'h13);
            end
            K_OP:
            begin
                f3 = rand_bits(3);
                f7 = ((f3 == 32'd0 || f3 == 32'd5) && rand_bits(1) == 32'd1) ? 32'h20 : 32'h0;
                mem[k[11:0]] = enc_r(f7, rand_bits(5), rand_bits(5), f3, rand_bits(5));
            end
            K_BR:
            begin
                t  = pick_target(k);
                f3 = rand_bits(3);
                if (f3 == 32'd2 || f3 == 32'd3)
                    f3 = 32'd0;
                mem[k[11:0]] = enc_b(32'((t - k) * 4), rand_bits(5), rand_bits(5), f3);
            end
            K_JAL:
            begin
                t = pick_target(k);
                mem[k[11:0]] = enc_j(32'((t - k) * 4), rand_bits(5));
            end
            K_BASE:
            begin
                // addi xN, x0, target followed by jalr through xN
                t = pick_target(k + 1);
                f7 = 32'(1 + int'(rand_bits(5)) % 31);
                mem[k[11:0]] = enc_i(32'(t * 4), 32'd0, 32'd0, f7, 32'h13);
                mem[k[11:0] + 12'd1] = enc_i(rand_bits(1), f7, 32'd0, rand_bits(5), 32'h67);
            end
            default:
            begin
            end
        endcase
    end
endtask

function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

task automatic model_step(output retire_t exp);
    logic [31:0] inst;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] npc;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic        wr;
    logic        take;
    inst  = mem[m_pc[13:2]];
    a     = m_regs[inst[19:15]];
    b     = m_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    imm_u = {inst[31:12], 12'b0};
    imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    res   = '0;
    npc   = m_pc + 32'd4;
    wr    = 1'b1;
    take  = 1'b0;
    case (inst[6:0])
        7'b0110111: res = imm_u;
        7'b0010111: res = m_pc + imm_u;
        7'b1101111:
        begin
            res = m_pc + 32'd4;
            npc = m_pc + imm_j;
        end
        7'b1100111:
        begin
            res = m_pc + 32'd4;
            npc = (a + imm_i) & ~32'd1;
        end
        7'b1100011:
        begin
            wr = 1'b0;
            case (inst[14:12])
                3'b000:  take = (a == b);
                3'b001:  take = (a != b);
                3'b100:  take = ($signed(a) < $signed(b));
                3'b101:  take = ($signed(a) >= $signed(b));
                3'b110:  take = (a < b);
                default: take = (a >= b);
            endcase
            if (take)
                npc = m_pc + imm_b;
        end
        7'b0010011: res = alu_model(inst[14:12], (inst[14:12] == 3'b101) && inst[30], a, imm_i);
        7'b0110011: res = alu_model(inst[14:12], inst[30], a, b);
        default:    wr = 1'b0;
    endcase
    exp         = '0;
    exp.valid   = 1'b1;
    exp.pc      = m_pc;
    exp.rd_we   = wr && (inst[11:7] != 5'd0);
    exp.rd      = inst[11:7];
    exp.rd_data = res;
    exp.next_pc = npc;
    exp.inst    = inst;
    if (exp.rd_we)
        m_regs[inst[11:7]] = res;
    m_pc = npc;
endtask

task automatic stop_with_failure();
    $display("Simulation finished: FAIL");
    $fatal(1);
endtask

// rd_data only matters when the register is written
task automatic check_retire(input retire_t got, input retire_t exp);
    retire_t g;
    retire_t e;
    g = got;
    e = exp;
    if (!e.rd_we)
    begin
        g.rd_data = '0;
        e.rd_data = '0;
    end
    if (g !== e)
    begin
        $display("[ERROR] %0t o_retire got %h expected %h", $time, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_halt(input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("[ERROR] %0t o_is_halted got %b expected %b", $time, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_valid(input logic got, input logic exp);
    if (got !== exp)
    begin
        $display("[ERROR] %0t o_retire.valid got %b expected %b", $time, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_addr(input logic [`RV_MEM_AW-1:0] got,
                          input logic [`RV_MEM_AW-1:0] exp);
    if (got !== exp)
    begin
        $display("[ERROR] %0t o_mem_addr got %h expected %h", $time, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_spacing(input int got, input int exp);
    if (got != exp)
    begin
        $display("[ERROR] %0t retire spacing got %0d expected %0d", $time, got, exp);
        stop_with_failure();
    end
endtask

task automatic apply_reset();
    @(posedge clk);
    rerun_rst <= 1'b1;
    repeat (10) @(posedge clk);
    rerun_rst <= 1'b0;
endtask

task automatic run_program();
    retire_t               exp;
    int                    gap;
    logic                  low_seen;
    logic                  have_prev;
    logic                  en_prev;
    logic [`RV_MEM_AW-1:0] addr_prev;
    gap       = 0;
    low_seen  = 1'b0;
    have_prev = 1'b0;
    m_pc      = '0;
    for (int r = 0; r < 32; r++)
        m_regs[r] = '0;
    // first look once a reset edge has reached the core
    wait (dut_rst);
    @(posedge clk);
    @(negedge clk);
    while (dut_rst)
    begin
        check_addr(mem_addr, '0);
        check_valid(retire.valid, 1'b0);
        check_halt(halted, 1'b0);
        @(negedge clk);
    end
    en_prev   = 1'b1;
    addr_prev = mem_addr;
    while (!(halted && mem[m_pc[13:2]] == 32'd0))
    begin
        if (!en_prev)
        begin
            check_addr(mem_addr, addr_prev);
            check_valid(retire.valid, 1'b0);
            low_seen = 1'b1;
        end
        gap = gap + 1;
        if (retire.valid)
        begin
            if (mem[m_pc[13:2]] == 32'd0)
            begin
                $display("retire seen after the halting word at time %0t", $time);
                stop_with_failure();
            end
            model_step(exp);
            check_retire(retire, exp);
            if (have_prev && !low_seen)
                check_spacing(gap, 4);
            gap       = 0;
            low_seen  = 1'b0;
            have_prev = 1'b1;
        end
        if (mem[m_pc[13:2]] != 32'd0)
            check_halt(halted, 1'b0);
        en_prev   = enable;
        addr_prev = mem_addr;
        @(negedge clk);
    end
    repeat (50)
    begin
        @(negedge clk);
        check_halt(halted, 1'b1);
        check_valid(retire.valid, 1'b0);
    end
endtask

initial
begin
    #(LIMIT_CYCLES * 10);
    $display("watchdog expired before the program halted");
    stop_with_failure();
end

initial
begin
    enable     = 1'b0;
    mem_data   = '0;
    rerun_rst  = 1'b0;
    lfsr_state = 16'd39607;
    build_program();
    run_program();
    fork
        apply_reset();
        run_program();
    join
    $display("Simulation finished: PASS");
    $finish;
end

endmodule

`default_nettype wire
